// ==== muldiv_pkg.sv ====
package muldiv_pkg;

  // datapath width
  localparam int XLEN = 32;

  // one operand or result word
  typedef logic [XLEN-1:0] word_t;

  // reorder buffer tag
  localparam int ROB_TAG_W = 3;

  typedef logic [ROB_TAG_W-1:0] rob_tag_t;

  // station geometry
  localparam int RS_ENTRIES = 8;
  localparam int RS_IDX_W = 3;

  typedef logic [RS_IDX_W-1:0] rs_idx_t;

  // funct3 encodings of the M extension
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } muldiv_op_e;

  // start to done, multiplier
  // 32 shift-add steps plus the output cycle
  localparam int MUL_CYCLES = 33;

  // start to done, divider
  // 32 restoring steps, one sign fix, one output cycle
  localparam int DIV_CYCLES = 34;

endpackage

// ==== rs_station.sv ====
`timescale 1ns/10ps

module rs_station
  import muldiv_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  logic                  issue_valid,
  input  muldiv_op_e            issue_op,
  input  logic                  issue_rs1_ready,
  input  logic                  issue_rs2_ready,
  input  word_t                 issue_rs1_value,
  input  word_t                 issue_rs2_value,
  input  rob_tag_t              issue_rs1_tag,
  input  rob_tag_t              issue_rs2_tag,
  input  rob_tag_t              issue_dest_tag,
  input  logic                  cdb_in_valid,
  input  rob_tag_t              cdb_in_tag,
  input  word_t                 cdb_in_value,
  input  rs_idx_t               sel_idx,
  input  logic                  free_valid,
  input  rs_idx_t               free_idx,
  output logic                  rs_full,
  output logic [RS_ENTRIES-1:0] entry_ready,
  output muldiv_op_e            sel_op,
  output word_t                 sel_a,
  output word_t                 sel_b,
  output rob_tag_t              sel_tag
);

  // per-entry control flags
  logic [RS_ENTRIES-1:0] busy;
  logic [RS_ENTRIES-1:0] rdy1;
  logic [RS_ENTRIES-1:0] rdy2;

  // per-entry payload
  muldiv_op_e op_arr   [RS_ENTRIES];
  word_t      val1     [RS_ENTRIES];
  word_t      val2     [RS_ENTRIES];
  rob_tag_t   tag1     [RS_ENTRIES];
  rob_tag_t   tag2     [RS_ENTRIES];
  rob_tag_t   dest_arr [RS_ENTRIES];

  // lowest free slot
  rs_idx_t free_slot;
  logic    has_free;

  // per-entry write strobes
  logic [RS_ENTRIES-1:0] take;
  logic [RS_ENTRIES-1:0] wake1;
  logic [RS_ENTRIES-1:0] wake2;

  // scan from the top so the lowest free index wins
  always_comb begin
    has_free  = 1'b0;
    free_slot = '0;
    for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        has_free  = 1'b1;
        free_slot = rs_idx_t'(i);
      end
    end
  end

  assign rs_full = !has_free;

  always_comb begin
    for (int i = 0; i < RS_ENTRIES; i++) begin
      take[i]  = issue_valid && has_free && (free_slot == rs_idx_t'(i));
      // only waiting operands of live entries listen to the snoop bus
      wake1[i] = cdb_in_valid && busy[i] && !rdy1[i] && (cdb_in_tag == tag1[i]);
      wake2[i] = cdb_in_valid && busy[i] && !rdy2[i] && (cdb_in_tag == tag2[i]);
    end
  end

  // both operands present
  assign entry_ready = busy & rdy1 & rdy2;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      busy <= '0;
      rdy1 <= '0;
      rdy2 <= '0;
    end else begin
      for (int i = 0; i < RS_ENTRIES; i++) begin
        if (take[i]) begin
          busy[i] <= 1'b1;
          rdy1[i] <= issue_rs1_ready;
          rdy2[i] <= issue_rs2_ready;
        end else begin
          if (wake1[i]) begin
            rdy1[i] <= 1'b1;
          end
          if (wake2[i]) begin
            rdy2[i] <= 1'b1;
          end
        end
      end
      // pop on completion, never the slot being filled
      if (free_valid) begin
        busy[free_idx] <= 1'b0;
        rdy1[free_idx] <= 1'b0;
        rdy2[free_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_ENTRIES; i++) begin
      if (take[i]) begin
        op_arr[i]   <= issue_op;
        val1[i]     <= issue_rs1_value;
        val2[i]     <= issue_rs2_value;
        tag1[i]     <= issue_rs1_tag;
        tag2[i]     <= issue_rs2_tag;
        dest_arr[i] <= issue_dest_tag;
      end else begin
        // captured value from the broadcast
        if (wake1[i]) begin
          val1[i] <= cdb_in_value;
        end
        if (wake2[i]) begin
          val2[i] <= cdb_in_value;
        end
      end
    end
  end

  // read port for the scheduler and units
  assign sel_op  = op_arr[sel_idx];
  assign sel_a   = val1[sel_idx];
  assign sel_b   = val2[sel_idx];
  assign sel_tag = dest_arr[sel_idx];

endmodule

// ==== muldiv_sched.sv ====
`timescale 1ns/10ps

module muldiv_sched
  import muldiv_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  logic [RS_ENTRIES-1:0] entry_ready,
  input  muldiv_op_e            sel_op,
  input  rob_tag_t              sel_tag,
  input  logic                  mul_done,
  input  word_t                 mul_result,
  input  logic                  div_done,
  input  word_t                 div_result,
  output rs_idx_t               sel_idx,
  output logic                  mul_start,
  output logic                  div_start,
  output logic                  free_valid,
  output rs_idx_t               free_idx,
  output logic                  cdb_out_valid,
  output rob_tag_t              cdb_out_tag,
  output word_t                 cdb_out_value
);

  // one op in flight across both units
  logic     busy;
  logic     start_q;
  // round-robin base
  rs_idx_t  rr;
  // tag of the op in flight
  rob_tag_t tag_q;

  // scan results
  rs_idx_t  scan_idx;
  rs_idx_t  pick_idx;
  logic     pick_ok;
  logic     done_any;

  // first ready entry at or after rr
  // walk backwards so the smallest offset is assigned last
  always_comb begin
    pick_ok  = 1'b0;
    pick_idx = rr;
    scan_idx = rr;
    for (int k = RS_ENTRIES - 1; k >= 0; k--) begin
      scan_idx = rr + rs_idx_t'(k);
      if (entry_ready[scan_idx]) begin
        pick_ok  = 1'b1;
        pick_idx = scan_idx;
      end
    end
  end

  assign done_any = mul_done || div_done;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      busy    <= 1'b0;
      start_q <= 1'b0;
      rr      <= '0;
      sel_idx <= '0;
    end else begin
      start_q <= 1'b0;
      if (!busy && pick_ok) begin
        busy    <= 1'b1;
        start_q <= 1'b1;
        sel_idx <= pick_idx;
      end
      // busy drops with done, so the next start is two cycles out
      if (done_any) begin
        busy <= 1'b0;
        rr   <= sel_idx + rs_idx_t'(1);
      end
    end
  end

  // station read port already points at the pick
  always_ff @(posedge clk) begin
    if (start_q) begin
      tag_q <= sel_tag;
    end
  end

  // unit selection by op class
  assign mul_start = start_q && (sel_op inside {MUL, MULH, MULHSU, MULHU});
  assign div_start = start_q && (sel_op inside {DIV, DIVU, REM, REMU});

  // result broadcast and pop in the done cycle
  assign cdb_out_valid = done_any;
  assign cdb_out_tag   = tag_q;
  assign cdb_out_value = div_done ? div_result : mul_result;
  assign free_valid    = done_any;
  assign free_idx      = sel_idx;

endmodule

// ==== seq_multiplier.sv ====
`timescale 1ns/10ps

module seq_multiplier
  import muldiv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush,
  input  logic       start,
  input  muldiv_op_e op,
  input  word_t      a,
  input  word_t      b,
  output logic       done,
  output word_t      result
);

  // control
  logic       busy;
  logic [5:0] cnt;

  // operands and partial product
  muldiv_op_e        op_q;
  logic              neg_q;
  logic [2*XLEN-1:0] mcand;
  word_t             mplier;
  logic [2*XLEN-1:0] prod;

  // sign handling
  logic              a_sgn;
  logic              b_sgn;
  word_t             a_mag;
  word_t             b_mag;
  logic [2*XLEN-1:0] prod_fix;

  // rs1 signed for all but MULHU, rs2 signed for MUL and MULH
  assign a_sgn = (op inside {MUL, MULH, MULHSU}) && a[XLEN-1];
  assign b_sgn = (op inside {MUL, MULH}) && b[XLEN-1];
  assign a_mag = a_sgn ? -a : a;
  assign b_mag = b_sgn ? -b : b;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (start) begin
      busy <= 1'b1;
      cnt  <= 6'd1;
    end else if (busy) begin
      if (cnt == 6'(MUL_CYCLES)) begin
        busy <= 1'b0;
      end
      cnt <= cnt + 6'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_q   <= op;
      neg_q  <= a_sgn ^ b_sgn;
      mcand  <= {{XLEN{1'b0}}, a_mag};
      mplier <= b_mag;
      prod   <= '0;
    end else if (busy && cnt <= 6'(XLEN)) begin
      // one multiplier bit per cycle, lsb first
      if (mplier[0]) begin
        prod <= prod + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign done     = busy && (cnt == 6'(MUL_CYCLES));
  assign prod_fix = neg_q ? -prod : prod;
  // low word only for MUL
  assign result   = (op_q == MUL) ? prod_fix[XLEN-1:0] : prod_fix[2*XLEN-1:XLEN];

endmodule

// ==== seq_divider.sv ====
`timescale 1ns/10ps

module seq_divider
  import muldiv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush,
  input  logic       start,
  input  muldiv_op_e op,
  input  word_t      a,
  input  word_t      b,
  output logic       done,
  output word_t      result
);

  // control
  logic       busy;
  logic [5:0] cnt;

  // operands and working registers
  muldiv_op_e op_q;
  word_t      dvd_q;
  word_t      dvs;
  word_t      quo;
  word_t      rem;
  logic       zero_q;
  logic       ovf_q;
  logic       neg_quo_q;
  logic       neg_rem_q;
  word_t      res_q;

  // sign handling at start
  logic  sgn_op;
  logic  a_sgn;
  logic  b_sgn;
  word_t a_mag;
  word_t b_mag;

  // one restoring step
  logic [XLEN:0]   rem_sh;
  logic [XLEN+1:0] trial;

  // final fix-up
  word_t q_fix;
  word_t r_fix;

  assign sgn_op = op inside {DIV, REM};
  assign a_sgn  = sgn_op && a[XLEN-1];
  assign b_sgn  = sgn_op && b[XLEN-1];
  assign a_mag  = a_sgn ? -a : a;
  assign b_mag  = b_sgn ? -b : b;

  // shift next dividend bit in, try the subtract
  assign rem_sh = {rem, quo[XLEN-1]};
  assign trial  = {1'b0, rem_sh} - {2'b00, dvs};

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (start) begin
      busy <= 1'b1;
      cnt  <= 6'd1;
    end else if (busy) begin
      if (cnt == 6'(DIV_CYCLES)) begin
        busy <= 1'b0;
      end
      cnt <= cnt + 6'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_q      <= op;
      dvd_q     <= a;
      dvs       <= b_mag;
      quo       <= a_mag;
      rem       <= '0;
      zero_q    <= (b == '0);
      // most negative over minus one
      ovf_q     <= sgn_op && (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
      neg_quo_q <= a_sgn ^ b_sgn;
      // remainder follows the dividend
      neg_rem_q <= a_sgn;
    end else if (busy && cnt <= 6'(XLEN)) begin
      if (!trial[XLEN+1]) begin
        rem <= trial[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b1};
      end else begin
        rem <= rem_sh[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b0};
      end
    end else if (busy && cnt == 6'(DIV_CYCLES - 1)) begin
      res_q <= (op_q inside {DIV, DIVU}) ? q_fix : r_fix;
    end
  end

  // riscv special cases override the signed result
  always_comb begin
    if (zero_q) begin
      q_fix = '1;
      r_fix = dvd_q;
    end else if (ovf_q) begin
      q_fix = dvd_q;
      r_fix = '0;
    end else begin
      q_fix = neg_quo_q ? -quo : quo;
      r_fix = neg_rem_q ? -rem : rem;
    end
  end

  assign done   = busy && (cnt == 6'(DIV_CYCLES));
  assign result = res_q;

endmodule

// ==== muldiv_rs.sv ====
`timescale 1ns/10ps

module muldiv_rs
  import muldiv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush,
  // issue side
  input  logic       issue_valid,
  input  muldiv_op_e issue_op,
  input  logic       issue_rs1_ready,
  input  word_t      issue_rs1_value,
  input  rob_tag_t   issue_rs1_tag,
  input  logic       issue_rs2_ready,
  input  word_t      issue_rs2_value,
  input  rob_tag_t   issue_rs2_tag,
  input  rob_tag_t   issue_dest_tag,
  output logic       rs_full,
  // snoop lane
  input  logic       cdb_in_valid,
  input  rob_tag_t   cdb_in_tag,
  input  word_t      cdb_in_value,
  // result lane
  output logic       cdb_out_valid,
  output rob_tag_t   cdb_out_tag,
  output word_t      cdb_out_value
);

  // station to scheduler
  logic [RS_ENTRIES-1:0] entry_ready;
  rs_idx_t               sel_idx;
  muldiv_op_e            sel_op;
  word_t                 sel_a;
  word_t                 sel_b;
  rob_tag_t              sel_tag;
  logic                  free_valid;
  rs_idx_t               free_idx;

  // scheduler to units
  logic  mul_start;
  logic  mul_done;
  word_t mul_result;
  logic  div_start;
  logic  div_done;
  word_t div_result;

  rs_station u_station (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush           (flush),
    .issue_valid     (issue_valid),
    .issue_op        (issue_op),
    .issue_rs1_ready (issue_rs1_ready),
    .issue_rs2_ready (issue_rs2_ready),
    .issue_rs1_value (issue_rs1_value),
    .issue_rs2_value (issue_rs2_value),
    .issue_rs1_tag   (issue_rs1_tag),
    .issue_rs2_tag   (issue_rs2_tag),
    .issue_dest_tag  (issue_dest_tag),
    .cdb_in_valid    (cdb_in_valid),
    .cdb_in_tag      (cdb_in_tag),
    .cdb_in_value    (cdb_in_value),
    .sel_idx         (sel_idx),
    .free_valid      (free_valid),
    .free_idx        (free_idx),
    .rs_full         (rs_full),
    .entry_ready     (entry_ready),
    .sel_op          (sel_op),
    .sel_a           (sel_a),
    .sel_b           (sel_b),
    .sel_tag         (sel_tag)
  );

  muldiv_sched u_sched (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .entry_ready   (entry_ready),
    .sel_op        (sel_op),
    .sel_tag       (sel_tag),
    .mul_done      (mul_done),
    .mul_result    (mul_result),
    .div_done      (div_done),
    .div_result    (div_result),
    .sel_idx       (sel_idx),
    .mul_start     (mul_start),
    .div_start     (div_start),
    .free_valid    (free_valid),
    .free_idx      (free_idx),
    .cdb_out_valid (cdb_out_valid),
    .cdb_out_tag   (cdb_out_tag),
    .cdb_out_value (cdb_out_value)
  );

  // both units read the station at sel_idx
  seq_multiplier u_mul (
    .clk    (clk),
    .rst_n  (rst_n),
    .flush  (flush),
    .start  (mul_start),
    .op     (sel_op),
    .a      (sel_a),
    .b      (sel_b),
    .done   (mul_done),
    .result (mul_result)
  );

  seq_divider u_div (
    .clk    (clk),
    .rst_n  (rst_n),
    .flush  (flush),
    .start  (div_start),
    .op     (sel_op),
    .a      (sel_a),
    .b      (sel_b),
    .done   (div_done),
    .result (div_result)
  );

endmodule

// ==== muldiv_rs_chk.sv ====
`timescale 1ns/10ps

module muldiv_rs_chk (
  input logic clk,
  input logic rst_n,
  input logic issue_valid,
  input logic rs_full,
  input logic cdb_out_valid
);

  // issuer holds off while the station is full
  assert property (@(posedge clk) disable iff (!rst_n) !(issue_valid && rs_full))
    else $error("issue_valid high while rs_full is set");

  // busy clears with done, so results are never back to back
  assert property (@(posedge clk) disable iff (!rst_n) cdb_out_valid |=> !cdb_out_valid)
    else $error("cdb_out_valid high on two consecutive cycles");

  // first cycle out of reset
  assert property (@(posedge clk) (rst_n && !$past(rst_n)) |-> !cdb_out_valid)
    else $error("cdb_out_valid high in the cycle after reset");

endmodule

bind muldiv_rs muldiv_rs_chk u_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .issue_valid   (issue_valid),
  .rs_full       (rs_full),
  .cdb_out_valid (cdb_out_valid)
);

// ==== tb_muldiv_rs.sv ====
`timescale 1ns/10ps

module tb_muldiv_rs
  import muldiv_pkg::*;
();

  logic       clk;
  logic       rst_n;
  logic       flush;
  logic       issue_valid;
  muldiv_op_e issue_op;
  logic       issue_rs1_ready;
  word_t      issue_rs1_value;
  rob_tag_t   issue_rs1_tag;
  logic       issue_rs2_ready;
  word_t      issue_rs2_value;
  rob_tag_t   issue_rs2_tag;
  rob_tag_t   issue_dest_tag;
  logic       rs_full;
  logic       cdb_in_valid;
  rob_tag_t   cdb_in_tag;
  word_t      cdb_in_value;
  logic       cdb_out_valid;
  rob_tag_t   cdb_out_tag;
  word_t      cdb_out_value;

  // scoreboard with one slot per destination tag
  word_t                   exp_val [2**ROB_TAG_W];
  logic [2**ROB_TAG_W-1:0] pending;
  // tags of flushed ops that must never come back
  logic [2**ROB_TAG_W-1:0] blocked;
  // set while every outstanding op still waits on a snoop
  logic                    hold_results;

  int          errors = 0;
  int          issued = 0;
  int          flushed = 0;
  int          received = 0;
  int          cycles = 0;
  logic [31:0] rng;

  muldiv_rs uut (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush           (flush),
    .issue_valid     (issue_valid),
    .issue_op        (issue_op),
    .issue_rs1_ready (issue_rs1_ready),
    .issue_rs1_value (issue_rs1_value),
    .issue_rs1_tag   (issue_rs1_tag),
    .issue_rs2_ready (issue_rs2_ready),
    .issue_rs2_value (issue_rs2_value),
    .issue_rs2_tag   (issue_rs2_tag),
    .issue_dest_tag  (issue_dest_tag),
    .rs_full         (rs_full),
    .cdb_in_valid    (cdb_in_valid),
    .cdb_in_tag      (cdb_in_tag),
    .cdb_in_value    (cdb_in_value),
    .cdb_out_valid   (cdb_out_valid),
    .cdb_out_tag     (cdb_out_tag),
    .cdb_out_value   (cdb_out_value)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // expected RV32M result
  function automatic word_t ref_muldiv(input muldiv_op_e op, input word_t a, input word_t b);
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] p;
    word_t       r;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'd0, a};
    ub = {32'd0, b};
    r  = '0;
    // low 64 bits of the product are exact for every sign mix
    case (op)
      MUL: begin
        p = ua * ub;
        r = p[31:0];
      end
      MULH: begin
        p = sa * sb;
        r = p[63:32];
      end
      MULHSU: begin
        p = sa * ub;
        r = p[63:32];
      end
      MULHU: begin
        p = ua * ub;
        r = p[63:32];
      end
      DIV: begin
        if (b == 32'd0) begin
          r = 32'hffff_ffff;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
          r = a;
        end else begin
          r = $signed(a) / $signed(b);
        end
      end
      DIVU: begin
        r = (b == 32'd0) ? 32'hffff_ffff : a / b;
      end
      REM: begin
        if (b == 32'd0) begin
          r = a;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
          r = 32'd0;
        end else begin
          // sv remainder takes the dividend's sign too
          r = $signed(a) % $signed(b);
        end
      end
      default: begin
        r = (b == 32'd0) ? a : a % b;
      end
    endcase
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("FAIL %0t ns %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic draw(output word_t w);
    rng = xorshift32(rng);
    w   = rng;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
    end
    #1;
  endtask

  // b is the value the op must end up using whether ready now or snooped later
  task automatic issue_one(input muldiv_op_e op, input word_t a, input word_t b,
                           input logic b_ready, input rob_tag_t b_tag);
    rob_tag_t dest;
    while (rs_full || (&(pending | blocked))) begin
      @(posedge clk);
      #1;
    end
    dest = '0;
    for (int t = 2**ROB_TAG_W - 1; t >= 0; t--) begin
      if (!pending[t] && !blocked[t]) begin
        dest = rob_tag_t'(t);
      end
    end
    issue_valid     = 1'b1;
    issue_op        = op;
    issue_rs1_ready = 1'b1;
    issue_rs1_value = a;
    issue_rs1_tag   = '0;
    issue_rs2_ready = b_ready;
    // stale value for a waiting operand
    issue_rs2_value = b_ready ? b : ~b;
    issue_rs2_tag   = b_tag;
    issue_dest_tag  = dest;
    exp_val[dest]   = ref_muldiv(op, a, b);
    pending[dest]   = 1'b1;
    issued++;
    @(posedge clk);
    #1;
    issue_valid = 1'b0;
  endtask

  task automatic snoop(input rob_tag_t t, input word_t v);
    cdb_in_valid = 1'b1;
    cdb_in_tag   = t;
    cdb_in_value = v;
    @(posedge clk);
    #1;
    cdb_in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (pending != '0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // result bus is settled mid-cycle
  always @(negedge clk) begin
    if (rst_n && cdb_out_valid) begin
      if (hold_results) begin
        errors++;
        $display("result for tag %0d at %0t ns came before its operand was broadcast",
                 cdb_out_tag, $time);
      end
      if (blocked[cdb_out_tag]) begin
        errors++;
        $display("flushed tag %0d appeared on the result bus at %0t ns", cdb_out_tag, $time);
      end else if (!pending[cdb_out_tag]) begin
        errors++;
        $display("result with tag %0d at %0t ns matches no outstanding op",
                 cdb_out_tag, $time);
      end else begin
        check_value("cdb_out_value", exp_val[cdb_out_tag], cdb_out_value);
        pending[cdb_out_tag] = 1'b0;
        received++;
      end
    end
  end

  // watchdog budget grows with every issue
  always @(posedge clk) begin
    cycles++;
    if (cycles > issued * (DIV_CYCLES + 4) + 200) begin
      $display("timeout after %0d cycles with %0d results missing", cycles,
               $countones(pending));
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    word_t      a;
    word_t      b;
    word_t      v;
    muldiv_op_e op;

    rst_n           = 1'b0;
    flush           = 1'b0;
    issue_valid     = 1'b0;
    issue_op        = MUL;
    issue_rs1_ready = 1'b0;
    issue_rs1_value = '0;
    issue_rs1_tag   = '0;
    issue_rs2_ready = 1'b0;
    issue_rs2_value = '0;
    issue_rs2_tag   = '0;
    issue_dest_tag  = '0;
    cdb_in_valid    = 1'b0;
    cdb_in_tag      = '0;
    cdb_in_value    = '0;
    pending         = '0;
    blocked         = '0;
    hold_results    = 1'b0;
    rng             = 32'h898ec4bc;

    // two reset edges with quiet outputs during and after
    @(posedge clk);
    @(negedge clk);
    check_value("rs_full", 32'd0, 32'(rs_full));
    check_value("cdb_out_valid", 32'd0, 32'(cdb_out_valid));
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("rs_full", 32'd0, 32'(rs_full));
    check_value("cdb_out_valid", 32'd0, 32'(cdb_out_valid));
    @(posedge clk);
    #1;

    // random ops with all operands ready
    repeat (40) begin
      draw(v);
      op = muldiv_op_e'(v[2:0]);
      draw(a);
      draw(b);
      issue_one(op, a, b, 1'b1, '0);
    end

    // overflow, divide by zero and extreme products
    issue_one(DIV, 32'h8000_0000, 32'hffff_ffff, 1'b1, '0);
    issue_one(REM, 32'h8000_0000, 32'hffff_ffff, 1'b1, '0);
    issue_one(DIV, 32'h1234_5678, 32'h0000_0000, 1'b1, '0);
    issue_one(DIVU, 32'hdead_beef, 32'h0000_0000, 1'b1, '0);
    issue_one(REM, 32'hfedc_ba98, 32'h0000_0000, 1'b1, '0);
    issue_one(REMU, 32'h0000_0007, 32'h0000_0000, 1'b1, '0);
    issue_one(MULH, 32'h8000_0000, 32'h8000_0000, 1'b1, '0);
    issue_one(MULHSU, 32'hffff_fff6, 32'h1234_5678, 1'b1, '0);
    issue_one(MULHSU, 32'h8000_0000, 32'hffff_ffff, 1'b1, '0);
    issue_one(DIV, 32'hffff_fff9, 32'h0000_0002, 1'b1, '0);
    issue_one(REM, 32'hffff_fff9, 32'h0000_0002, 1'b1, '0);
    wait_drain();

    // wake-up on tag 5 only
    draw(v);
    hold_results = 1'b1;
    draw(a);
    issue_one(MUL, a, v, 1'b0, 3'd5);
    draw(a);
    issue_one(DIVU, a, v, 1'b0, 3'd5);
    draw(a);
    issue_one(REM, a, v, 1'b0, 3'd5);
    idle(40);
    snoop(3'd3, ~v);
    idle(40);
    hold_results = 1'b0;
    snoop(3'd5, v);
    wait_drain();

    // fill all eight entries, then release them together
    draw(v);
    repeat (RS_ENTRIES) begin
      draw(b);
      op = muldiv_op_e'(b[2:0]);
      draw(a);
      issue_one(op, a, v, 1'b0, 3'd6);
    end
    check_value("rs_full", 32'd1, 32'(rs_full));
    snoop(3'd6, v);
    wait_drain();
    check_value("rs_full", 32'd0, 32'(rs_full));

    // flush a full station of waiting ops
    draw(v);
    repeat (RS_ENTRIES) begin
      draw(a);
      issue_one(MULHU, a, v, 1'b0, 3'd2);
    end
    check_value("rs_full", 32'd1, 32'(rs_full));
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    blocked = pending;
    pending = '0;
    flushed += RS_ENTRIES;
    check_value("rs_full", 32'd0, 32'(rs_full));
    // a leftover entry would wake here and finish within the window
    snoop(3'd2, v);
    idle(DIV_CYCLES + 20);
    blocked = '0;

    // fresh ops after the flush
    repeat (4) begin
      draw(v);
      op = muldiv_op_e'(v[2:0]);
      draw(a);
      draw(b);
      issue_one(op, a, b, 1'b1, '0);
    end
    wait_drain();
    idle(4);

    $display("errors %0d, results %0d of %0d", errors, received, issued - flushed);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
muldiv_pkg.sv
rs_station.sv
muldiv_sched.sv
seq_multiplier.sv
seq_divider.sv
muldiv_rs.sv
muldiv_rs_chk.sv
tb_muldiv_rs.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, and decide from the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_muldiv_rs -f tb.f \
  && ./obj_dir/Vtb_muldiv_rs > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation passed" sim.log && exit 0 || exit 1
